// File: Bender.yml
package:
  name: fetch_stage2

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fetchPkg.sv
      - source/preDecode.sv
      - source/btbValidate.sv
      - source/ctiQueue.sv
      - source/fetchStage2.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/fetchStage2Tb.sv

// File: all.f
+incdir+source
source/fetchPkg.sv
source/preDecode.sv
source/btbValidate.sv
source/ctiQueue.sv
source/fetchStage2.sv
dv/fetchStage2Tb.sv

// File: dv/fetchStage2Tb.sv
//--------------------
// testbench for fetch stage 2 that checks random bundles against a model
// of the pre-decode, the BTB check and the CTI queue.
//--------------------
`include "fetchStage_consts.svh"

module fetchStage2Tb
  import fetchPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH = 1 << `CTIQ_DEPTH_LOG;
  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_CYCLES = 2000;
  localparam int CYCLE_LIMIT = RESET_CYCLES + RANDOM_CYCLES + 50;

  logic clk;
  logic rstN_i;
  logic fs1Ready_i;
  pc_t pc_i;
  logic [`FETCH_WIDTH*`INSN_BITS-1:0] bundle_i;
  slotMask_t btbHit_i;
  slotMask_t predTaken_i;
  pc_t btbTarget_i [`FETCH_WIDTH];
  pc_t rasTop_i;
  logic stall_i;
  logic flush_i;
  logic resolveEn_i;
  ctiTag_t resolveTag_i;
  pc_t resolveTarget_i;
  logic resolveTaken_i;
  logic mispredict_i;
  logic commitCti_i;
  logic recoverFlag_i;
  slotMask_t instValid_o;
  insn_t insn_o [`FETCH_WIDTH];
  pc_t instPc_o [`FETCH_WIDTH];
  pc_t instTarget_o [`FETCH_WIDTH];
  ctiTag_t instTag_o [`FETCH_WIDTH];
  slotMask_t instPred_o;
  logic redirect_o;
  logic redirectRtr_o;
  logic redirectCall_o;
  pc_t redirectTarget_o;
  pc_t callPc_o;
  logic updateEn_o;
  pc_t updatePc_o;
  pc_t updateTarget_o;
  ctrlType_e updateType_o;
  logic updateTaken_o;
  logic fs2Ready_o;

  // queue model.
  pc_t mPc [DEPTH];
  pc_t mTarget [DEPTH];
  ctrlType_e mType [DEPTH];
  logic mTaken [DEPTH];
  ctiTag_t mHead = '0;
  ctiTag_t mTail = '0;
  int mCount = 0;

  // expected outputs for the next cycle.
  slotMask_t expValid, expAlloc, expPred;
  insn_t expInsn [`FETCH_WIDTH];
  pc_t expPc [`FETCH_WIDTH];
  pc_t expTarget [`FETCH_WIDTH];
  ctiTag_t expTag [`FETCH_WIDTH];
  logic expRedir, expRtr, expCall, expUpdEn, expUpdTaken;
  pc_t expRedirTarget, expCallPc, expUpdPc, expUpdTarget;
  ctrlType_e expUpdType;

  logic [31:0] lfsr = 32'd2;
  int checks = 0;
  int errors = 0;
  int accepted = 0;
  int cycles = 0;

  fetchStage2 dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic pc_t directTarget(input pc_t pc, input insn_t insn);
    int offset;
    offset = $signed(insn[15:0]);
    return pc + 32'd4 + pc_t'(offset * 4);
  endfunction

  task automatic reportMismatch(input string name, input string expS, input string actS);
    errors++;
    $display("CHECK FAILED at %0t: %s expected %s, got %s", $time, name, expS, actS);
  endtask

  task automatic checkPc(input string name, input pc_t expV, input pc_t actV);
    checks++;
    if (actV !== expV) reportMismatch(name, $sformatf("%h", expV), $sformatf("%h", actV));
  endtask

  task automatic checkInsn(input string name, input insn_t expV, input insn_t actV);
    checks++;
    if (actV !== expV) reportMismatch(name, $sformatf("%h", expV), $sformatf("%h", actV));
  endtask

  task automatic checkMask(input string name, input slotMask_t expV, input slotMask_t actV);
    checks++;
    if (actV !== expV) reportMismatch(name, $sformatf("%b", expV), $sformatf("%b", actV));
  endtask

  task automatic checkTag(input string name, input ctiTag_t expV, input ctiTag_t actV);
    checks++;
    if (actV !== expV) reportMismatch(name, $sformatf("%0d", expV), $sformatf("%0d", actV));
  endtask

  task automatic checkType(input string name, input ctrlType_e expV, input ctrlType_e actV);
    checks++;
    if (actV !== expV) reportMismatch(name, $sformatf("%0d", expV), $sformatf("%0d", actV));
  endtask

  task automatic checkBit(input string name, input logic expV, input logic actV);
    checks++;
    if (actV !== expV) reportMismatch(name, $sformatf("%b", expV), $sformatf("%b", actV));
  endtask

  task automatic driveRandom();
    logic [5:0] opc;
    logic [31:0] body;
    insn_t insn;
    fs1Ready_i = randBits(3) != 0;
    stall_i = randBits(3) == 0;
    flush_i = randBits(5) == 0;
    pc_i = pc_t'(randBits(30) << 2);
    rasTop_i = pc_t'(randBits(30) << 2);
    btbHit_i = slotMask_t'(randBits(4));
    predTaken_i = slotMask_t'(randBits(4));
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      // about half of the slots carry a CTI.
      if (randBits(1)) begin
        case (randBits(2))
          0: opc = `OPC_JUMP;
          1: opc = `OPC_CALL;
          2: opc = `OPC_RETURN;
          default: opc = `OPC_BRANCH;
        endcase
      end else begin
        opc = 6'h10 | 6'(randBits(4));
      end
      body = randBits(26);
      insn = {opc, body[25:0]};
      bundle_i[k*`INSN_BITS +: `INSN_BITS] = insn;
      btbTarget_i[k] = randBits(1) ? directTarget(pc_i + 4 * k, insn) : pc_t'(randBits(32));
    end
    commitCti_i = randBits(1);
    recoverFlag_i = randBits(6) == 0;
    resolveEn_i = (mCount > 0) && randBits(1);
    resolveTag_i = ctiTag_t'(mHead + (randBits(3) % (mCount > 0 ? mCount : 1)));
    resolveTarget_i = pc_t'(randBits(30) << 2);
    resolveTaken_i = randBits(1);
    mispredict_i = resolveEn_i && (randBits(3) == 0);
  endtask

  // works out the next cycle's outputs and steps the queue model.
  task automatic modelCycle();
    ctrlType_e slotType [`FETCH_WIDTH];
    slotMask_t isCti, mask;
    logic accept, load, found, hit, pop;
    int allocNum, keep;
    ctiTag_t diff;
    insn_t insn;
    pc_t pc;
    accept = fs1Ready_i && !stall_i && (mCount <= DEPTH - `FETCH_WIDTH);
    load = accept && !flush_i;
    found = 1'b0;
    mask = '0;
    allocNum = 0;
    expRedir = 1'b0;
    expRtr = 1'b0;
    expCall = 1'b0;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      insn = bundle_i[k*`INSN_BITS +: `INSN_BITS];
      pc = pc_i + 4 * k;
      isCti[k] = 1'b1;
      case (insn[31:26])
        `OPC_JUMP: slotType[k] = CT_JUMP;
        `OPC_CALL: slotType[k] = CT_CALL;
        `OPC_RETURN: slotType[k] = CT_RETURN;
        `OPC_BRANCH: slotType[k] = CT_BRANCH;
        default: begin
          isCti[k] = 1'b0;
          slotType[k] = CT_JUMP;
        end
      endcase
      // a BTB hit with the wrong target counts as a miss.
      hit = btbHit_i[k] &&
            (slotType[k] == CT_RETURN || btbTarget_i[k] == directTarget(pc, insn));
      expInsn[k] = insn;
      expPc[k] = pc;
      expTarget[k] = (isCti[k] && slotType[k] == CT_RETURN) ? rasTop_i : directTarget(pc, insn);
      expTag[k] = mTail + allocNum;
      if (!found) begin
        mask[k] = 1'b1;
        if (isCti[k]) allocNum++;
        if (isCti[k] && (predTaken_i[k] || slotType[k] != CT_BRANCH)) begin
          found = 1'b1;
          expRedir = load && !hit;
          expRtr = load && !hit && slotType[k] == CT_RETURN;
          expCall = load && !hit && slotType[k] == CT_CALL;
          expRedirTarget = expTarget[k];
          expCallPc = pc;
        end
      end
    end
    expAlloc = isCti & mask;
    expPred = predTaken_i;
    expValid = load ? mask : '0;
    pop = commitCti_i && (mCount != 0);
    expUpdEn = pop;
    if (pop) begin
      expUpdPc = mPc[mHead];
      expUpdTarget = mTarget[mHead];
      expUpdType = mType[mHead];
      expUpdTaken = mTaken[mHead];
    end
    if (load) begin
      accepted++;
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
        if (expAlloc[k]) begin
          mPc[expTag[k]] = expPc[k];
          mType[expTag[k]] = slotType[k];
          mTarget[expTag[k]] = '0;
          mTaken[expTag[k]] = 1'b0;
        end
      end
    end
    if (resolveEn_i) begin
      mTarget[resolveTag_i] = resolveTarget_i;
      mTaken[resolveTag_i] = resolveTaken_i;
    end
    if (recoverFlag_i) begin
      mHead = '0;
      mTail = '0;
      mCount = 0;
    end else begin
      if (resolveEn_i && mispredict_i) begin
        diff = resolveTag_i - mHead;
        keep = int'(diff) + 1;
        mTail = resolveTag_i + 1'b1;
        mCount = keep - int'(pop);
      end else if (load) begin
        mTail = mTail + allocNum;
        mCount = mCount + allocNum - int'(pop);
      end else begin
        mCount = mCount - int'(pop);
      end
      if (pop) mHead = mHead + 1'b1;
    end
  endtask

  task automatic checkOutputs();
    checkMask("instValid_o", expValid, instValid_o);
    checkBit("redirect_o", expRedir, redirect_o);
    checkBit("redirectRtr_o", expRtr, redirectRtr_o);
    checkBit("redirectCall_o", expCall, redirectCall_o);
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      if (expValid[k]) begin
        checkInsn($sformatf("insn_o[%0d]", k), expInsn[k], insn_o[k]);
        checkPc($sformatf("instPc_o[%0d]", k), expPc[k], instPc_o[k]);
        checkPc($sformatf("instTarget_o[%0d]", k), expTarget[k], instTarget_o[k]);
        checkBit($sformatf("instPred_o[%0d]", k), expPred[k], instPred_o[k]);
        if (expAlloc[k]) checkTag($sformatf("instTag_o[%0d]", k), expTag[k], instTag_o[k]);
      end
    end
    if (expRedir) begin
      checkPc("redirectTarget_o", expRedirTarget, redirectTarget_o);
      checkPc("callPc_o", expCallPc, callPc_o);
    end
    checkBit("updateEn_o", expUpdEn, updateEn_o);
    if (expUpdEn) begin
      checkPc("updatePc_o", expUpdPc, updatePc_o);
      checkPc("updateTarget_o", expUpdTarget, updateTarget_o);
      checkType("updateType_o", expUpdType, updateType_o);
      checkBit("updateTaken_o", expUpdTaken, updateTaken_o);
    end
    checkBit("fs2Ready_o", fs1Ready_i && (mCount <= DEPTH - `FETCH_WIDTH), fs2Ready_o);
  endtask

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rstN_i = 1'b0;
    fs1Ready_i = 1'b0;
    pc_i = '0;
    bundle_i = '0;
    btbHit_i = '0;
    predTaken_i = '0;
    for (int k = 0; k < `FETCH_WIDTH; k++) btbTarget_i[k] = '0;
    rasTop_i = '0;
    stall_i = 1'b0;
    flush_i = 1'b0;
    resolveEn_i = 1'b0;
    resolveTag_i = '0;
    resolveTarget_i = '0;
    resolveTaken_i = 1'b0;
    mispredict_i = 1'b0;
    commitCti_i = 1'b0;
    recoverFlag_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rstN_i = 1'b1;
    // idle inputs, so the first check sees the reset state.
    modelCycle();
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      @(posedge clk);
      #5;
      checkOutputs();
      driveRandom();
      modelCycle();
    end
    @(posedge clk);
    #5;
    checkOutputs();
    $display("checks: %0d, errors: %0d, accepted bundles: %0d", checks, errors, accepted);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: source/btbValidate.sv
//--------------------
// checks the first taken CTI of a bundle against the BTB and trims the bundle.
//--------------------
`include "fetchStage_consts.svh"

module btbValidate
  import fetchPkg::*;
(
  input  slotMask_t isCtrl_i,
  input  ctrlType_e ctrlType_i [`FETCH_WIDTH],
  input  pc_t       target_i [`FETCH_WIDTH],
  input  slotMask_t btbHit_i,
  input  slotMask_t predTaken_i,
  input  pc_t       slotPc_i [`FETCH_WIDTH],
  input  pc_t       rasTop_i,
  output slotMask_t validMask_o,
  output slotMask_t allocMask_o,
  output pc_t       slotTarget_o [`FETCH_WIDTH],
  output logic      redirect_o,
  output logic      redirectRtr_o,
  output logic      redirectCall_o,
  output pc_t       redirectTarget_o,
  output pc_t       callPc_o
);

  slotMask_t isRtr;
  slotMask_t taken;

  for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : slotGen
    assign isRtr[k] = isCtrl_i[k] && (ctrlType_i[k] == CT_RETURN);
    // only a conditional branch can be predicted not taken.
    assign taken[k] = isCtrl_i[k] && (predTaken_i[k] || (ctrlType_i[k] != CT_BRANCH));
    assign slotTarget_o[k] = isRtr[k] ? rasTop_i : target_i[k];
  end

  always_comb begin
    logic found;
    found            = 1'b0;
    validMask_o      = '0;
    redirect_o       = 1'b0;
    redirectRtr_o    = 1'b0;
    redirectCall_o   = 1'b0;
    redirectTarget_o = '0;
    callPc_o         = '0;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      if (!found) begin
        validMask_o[k] = 1'b1;
        if (taken[k]) begin
          found            = 1'b1;
          redirectTarget_o = slotTarget_o[k];
          callPc_o         = slotPc_i[k];
          // a BTB miss on the taken CTI means fetch went down the wrong path.
          redirect_o       = !btbHit_i[k];
          redirectRtr_o    = !btbHit_i[k] && isRtr[k];
          redirectCall_o   = !btbHit_i[k] && (ctrlType_i[k] == CT_CALL);
        end
      end
    end
  end

  assign allocMask_o = isCtrl_i & validMask_o;

endmodule

// File: source/ctiQueue.sv
//--------------------
// circular queue of in-flight CTIs, from allocation in fetch to retirement.
//--------------------
`include "fetchStage_consts.svh"

module ctiQueue
  import fetchPkg::*;
#(
  parameter int DEPTH_LOG = `CTIQ_DEPTH_LOG
) (
  input  logic      clk,
  input  logic      rstN_i,
  input  logic      allocEn_i,
  input  slotMask_t allocMask_i,
  input  pc_t       slotPc_i [`FETCH_WIDTH],
  input  ctrlType_e slotType_i [`FETCH_WIDTH],
  input  logic      resolveEn_i,
  input  ctiTag_t   resolveTag_i,
  input  pc_t       resolveTarget_i,
  input  logic      resolveTaken_i,
  input  logic      mispredict_i,
  input  logic      commitCti_i,
  input  logic      recoverFlag_i,
  output ctiTag_t   slotTag_o [`FETCH_WIDTH],
  output logic      full_o,
  output logic      updateEn_o,
  output pc_t       updatePc_o,
  output pc_t       updateTarget_o,
  output ctrlType_e updateType_o,
  output logic      updateTaken_o
);

  localparam int DEPTH = 1 << DEPTH_LOG;

  typedef logic [DEPTH_LOG-1:0] ptr_t;
  typedef logic [DEPTH_LOG:0]   cnt_t;

  pc_t       pcQ [DEPTH];
  pc_t       targetQ [DEPTH];
  ctrlType_e typeQ [DEPTH];
  logic      takenQ [DEPTH];

  ptr_t head;
  ptr_t tail;
  cnt_t count;
  ptr_t allocIdx [`FETCH_WIDTH];
  cnt_t allocNum;
  ptr_t resolveIdx;
  ptr_t keepDist;
  logic pop;

  assign resolveIdx = ptr_t'(resolveTag_i);
  assign keepDist   = resolveIdx - head;
  assign pop        = commitCti_i && (count != '0);

  // full while a whole bundle of CTIs would not fit.
  assign full_o = count > cnt_t'(DEPTH - `FETCH_WIDTH);

  always_comb begin
    allocNum = '0;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      allocIdx[k]  = tail + ptr_t'(allocNum);
      slotTag_o[k] = ctiTag_t'(allocIdx[k]);
      if (allocMask_i[k]) begin
        allocNum = allocNum + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i || recoverFlag_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (resolveEn_i && mispredict_i) begin
        // everything younger than the mispredicted CTI is dropped.
        tail  <= resolveIdx + 1'b1;
        count <= cnt_t'(keepDist) + 1'b1 - cnt_t'(pop);
      end else if (allocEn_i) begin
        tail  <= tail + ptr_t'(allocNum);
        count <= count + allocNum - cnt_t'(pop);
      end else begin
        count <= count - cnt_t'(pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (allocEn_i) begin
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
        if (allocMask_i[k]) begin
          pcQ[allocIdx[k]]     <= slotPc_i[k];
          typeQ[allocIdx[k]]   <= slotType_i[k];
          targetQ[allocIdx[k]] <= '0;
          takenQ[allocIdx[k]]  <= 1'b0;
        end
      end
    end
    if (resolveEn_i) begin
      targetQ[resolveIdx] <= resolveTarget_i;
      takenQ[resolveIdx]  <= resolveTaken_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      updateEn_o <= 1'b0;
    end else begin
      updateEn_o <= pop;
    end
  end

  // retiring entry goes to the predictor one cycle after the commit.
  always_ff @(posedge clk) begin
    if (pop) begin
      updatePc_o     <= pcQ[head];
      updateTarget_o <= targetQ[head];
      updateType_o   <= typeQ[head];
      updateTaken_o  <= takenQ[head];
    end
  end

endmodule

// File: source/fetchPkg.sv
//--------------------
// fetch stage 2 types shared by the pre-decode, validate and queue blocks.
//--------------------
`include "fetchStage_consts.svh"

package fetchPkg;

  typedef logic [`INSN_BITS-1:0] insn_t;

  typedef logic [`PC_BITS-1:0] pc_t;

  // index into the CTI queue.
  typedef logic [`CTIQ_DEPTH_LOG-1:0] ctiTag_t;

  // one bit per slot, slot 0 oldest.
  typedef logic [`FETCH_WIDTH-1:0] slotMask_t;

  typedef enum logic [1:0] {
    CT_RETURN = 2'd0,
    CT_CALL   = 2'd1,
    CT_JUMP   = 2'd2,
    CT_BRANCH = 2'd3
  } ctrlType_e;

endpackage

// File: source/fetchStage2.sv
//--------------------
// fetch stage 2: pre-decodes a four-wide bundle, validates the BTB
// and tags each kept CTI in the CTI queue.
//--------------------
`include "fetchStage_consts.svh"

module fetchStage2
  import fetchPkg::*;
(
  input  logic                              clk,
  input  logic                              rstN_i,
  input  logic                              fs1Ready_i,
  input  pc_t                               pc_i,
  input  logic [`FETCH_WIDTH*`INSN_BITS-1:0] bundle_i,
  input  slotMask_t                         btbHit_i,
  input  slotMask_t                         predTaken_i,
  input  pc_t                               btbTarget_i [`FETCH_WIDTH],
  input  pc_t                               rasTop_i,
  input  logic                              stall_i,
  input  logic                              flush_i,
  input  logic                              resolveEn_i,
  input  ctiTag_t                           resolveTag_i,
  input  pc_t                               resolveTarget_i,
  input  logic                              resolveTaken_i,
  input  logic                              mispredict_i,
  input  logic                              commitCti_i,
  input  logic                              recoverFlag_i,
  output slotMask_t                         instValid_o,
  output insn_t                             insn_o [`FETCH_WIDTH],
  output pc_t                               instPc_o [`FETCH_WIDTH],
  output pc_t                               instTarget_o [`FETCH_WIDTH],
  output ctiTag_t                           instTag_o [`FETCH_WIDTH],
  output slotMask_t                         instPred_o,
  output logic                              redirect_o,
  output logic                              redirectRtr_o,
  output logic                              redirectCall_o,
  output pc_t                               redirectTarget_o,
  output pc_t                               callPc_o,
  output logic                              updateEn_o,
  output pc_t                               updatePc_o,
  output pc_t                               updateTarget_o,
  output ctrlType_e                         updateType_o,
  output logic                              updateTaken_o,
  output logic                              fs2Ready_o
);

  insn_t     slotInsn [`FETCH_WIDTH];
  pc_t       slotPc [`FETCH_WIDTH];
  pc_t       decTarget [`FETCH_WIDTH];
  ctrlType_e decType [`FETCH_WIDTH];
  pc_t       slotTarget [`FETCH_WIDTH];
  ctiTag_t   slotTag [`FETCH_WIDTH];
  slotMask_t isCtrl;
  slotMask_t btbGood;
  slotMask_t validMask;
  slotMask_t allocMask;
  logic      redirect;
  logic      redirectRtr;
  logic      redirectCall;
  pc_t       redirectTarget;
  pc_t       callPc;
  logic      ctiFull;
  logic      accept;

  assign accept     = fs1Ready_i && !stall_i && !ctiFull;
  assign fs2Ready_o = fs1Ready_i && !ctiFull;

  for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : slotGen
    assign slotInsn[k] = bundle_i[k*`INSN_BITS +: `INSN_BITS];
    assign slotPc[k]   = pc_i + pc_t'(4 * k);
    // a hit with a stale target is as good as a miss, returns use the RAS.
    assign btbGood[k]  = btbHit_i[k] &&
                         ((decType[k] == CT_RETURN) || (btbTarget_i[k] == decTarget[k]));

    preDecode preDecodeInst (
      .pc_i      (slotPc[k]),
      .insn_i    (slotInsn[k]),
      .isCtrl_o  (isCtrl[k]),
      .ctrlType_o(decType[k]),
      .target_o  (decTarget[k])
    );
  end

  btbValidate btbValidateInst (
    .isCtrl_i        (isCtrl),
    .ctrlType_i      (decType),
    .target_i        (decTarget),
    .btbHit_i        (btbGood),
    .predTaken_i     (predTaken_i),
    .slotPc_i        (slotPc),
    .rasTop_i        (rasTop_i),
    .validMask_o     (validMask),
    .allocMask_o     (allocMask),
    .slotTarget_o    (slotTarget),
    .redirect_o      (redirect),
    .redirectRtr_o   (redirectRtr),
    .redirectCall_o  (redirectCall),
    .redirectTarget_o(redirectTarget),
    .callPc_o        (callPc)
  );

  // a flushed bundle never reaches the queue.
  ctiQueue ctiQueueInst (
    .clk            (clk),
    .rstN_i         (rstN_i),
    .allocEn_i      (accept && !flush_i),
    .allocMask_i    (allocMask),
    .slotPc_i       (slotPc),
    .slotType_i     (decType),
    .resolveEn_i    (resolveEn_i),
    .resolveTag_i   (resolveTag_i),
    .resolveTarget_i(resolveTarget_i),
    .resolveTaken_i (resolveTaken_i),
    .mispredict_i   (mispredict_i),
    .commitCti_i    (commitCti_i),
    .recoverFlag_i  (recoverFlag_i),
    .slotTag_o      (slotTag),
    .full_o         (ctiFull),
    .updateEn_o     (updateEn_o),
    .updatePc_o     (updatePc_o),
    .updateTarget_o (updateTarget_o),
    .updateType_o   (updateType_o),
    .updateTaken_o  (updateTaken_o)
  );

  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      instValid_o    <= '0;
      redirect_o     <= 1'b0;
      redirectRtr_o  <= 1'b0;
      redirectCall_o <= 1'b0;
    end else begin
      instValid_o    <= accept ? validMask : '0;
      redirect_o     <= accept && redirect;
      redirectRtr_o  <= accept && redirectRtr;
      redirectCall_o <= accept && redirectCall;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      insn_o           <= slotInsn;
      instPc_o         <= slotPc;
      instTarget_o     <= slotTarget;
      instTag_o        <= slotTag;
      instPred_o       <= predTaken_i;
      redirectTarget_o <= redirectTarget;
      callPc_o         <= callPc;
    end
  end

endmodule

// File: source/fetchStage_consts.svh
//--------------------
// fetch stage 2 sizes and the opcode map of the control transfers.
//--------------------
`ifndef FETCHSTAGE_CONSTS_SVH
`define FETCHSTAGE_CONSTS_SVH

`define FETCH_WIDTH 4
`define INSN_BITS 32
`define PC_BITS 32

// log2 of the CTI queue depth.
`define CTIQ_DEPTH_LOG 3

// opcodes live in instruction bits 31:26.
`define OPC_JUMP 6'h02
`define OPC_CALL 6'h03
`define OPC_BRANCH 6'h04
`define OPC_RETURN 6'h08

`endif

// File: source/preDecode.sv
//--------------------
// pre-decoder for one slot: CTI flag, control type and direct target.
//--------------------
`include "fetchStage_consts.svh"

module preDecode
  import fetchPkg::*;
(
  input  pc_t       pc_i,
  input  insn_t     insn_i,
  output logic      isCtrl_o,
  output ctrlType_e ctrlType_o,
  output pc_t       target_o
);

  logic [5:0] opcode;
  pc_t        offset;

  assign opcode = insn_i[`INSN_BITS-1 -: 6];

  // word offset in bits 15:0, sign extended.
  assign offset = {{(`PC_BITS-18){insn_i[15]}}, insn_i[15:0], 2'b00};

  assign target_o = pc_i + pc_t'(4) + offset;

  always_comb begin
    isCtrl_o   = 1'b1;
    ctrlType_o = CT_JUMP;
    case (opcode)
      `OPC_JUMP:   ctrlType_o = CT_JUMP;
      `OPC_CALL:   ctrlType_o = CT_CALL;
      `OPC_RETURN: ctrlType_o = CT_RETURN;
      `OPC_BRANCH: ctrlType_o = CT_BRANCH;
      default: begin
        isCtrl_o = 1'b0;
      end
    endcase
  end

endmodule
